//--- frontEndParams.svh
`ifndef FRONT_END_PARAMS_SVH
`define FRONT_END_PARAMS_SVH

// Data path and instruction word width
`define XLEN 32

// Wishbone byte address width
`define ADDR_W 32

`define RESET_PC 32'h0000_0000  // First fetch address after reset

`define INST_STEP 32'd4  // No compressed instructions, so every word is four bytes

`endif

//--- frontEndPkg.sv
`include "frontEndParams.svh"

package frontEndPkg;

    typedef enum logic [5:0] {
        LUI, AUIPC, JAL, JALR,
        BEQ, BNE, BLT, BGE, BLTU, BGEU,
        LB, LH, LW, LBU, LHU,
        SB, SH, SW,
        ADDI, SLTI, SLTIU, XORI, ORI, ANDI, SLLI, SRLI, SRAI,
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND,
        NOP, ILLEGAL
    } opCode_e;

    typedef enum logic [6:0] {
        ClassLui    = 7'b0110111,
        ClassAuipc  = 7'b0010111,
        ClassJal    = 7'b1101111,
        ClassJalr   = 7'b1100111,
        ClassBranch = 7'b1100011,
        ClassLoad   = 7'b0000011,
        ClassStore  = 7'b0100011,
        ClassOpImm  = 7'b0010011,
        ClassOp     = 7'b0110011,
        ClassNop    = 7'b0000000  // Also used for anything that fails decode
    } opClass_e;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } rType_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } iType_t;

    typedef struct packed {
        logic [6:0] immHi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] immLo;
        logic [6:0] opcode;
    } sType_t;

    typedef struct packed {
        logic       immSign;  // imm[12]
        logic [5:0] immHi;    // imm[10:5]
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] immLo;    // imm[4:1]
        logic       imm11;
        logic [6:0] opcode;
    } bType_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } uType_t;

    typedef struct packed {
        logic       immSign;  // imm[20]
        logic [9:0] immLo;    // imm[10:1]
        logic       imm11;
        logic [7:0] immHi;    // imm[19:12]
        logic [4:0] rd;
        logic [6:0] opcode;
    } jType_t;

    typedef union packed {
        rType_t rType;
        iType_t iType;
        sType_t sType;
        bType_t bType;
        uType_t uType;
        jType_t jType;
    } instWord_u;

    typedef struct packed {
        logic               cyc;
        logic               stb;
        logic               we;
        logic [`ADDR_W-1:0] adr;
    } wbReq_t;

    typedef struct packed {
        logic             ack;
        logic [`XLEN-1:0] dat;
    } wbRsp_t;

    typedef struct packed {
        logic [4:0]         rs1Name;
        logic [4:0]         rs2Name;
        logic [4:0]         rdName;
        opCode_e            opCode;
        opClass_e           opClass;
        logic [`ADDR_W-1:0] instAddr;
        logic [`XLEN-1:0]   imm;
    } decodedInst_t;

endpackage

//--- instFetch.sv
`timescale 1ns/1ps
`include "frontEndParams.svh"

module instFetch import frontEndPkg::*; (
    input  logic               clk,
    input  logic               rstN,
    output wbReq_t             wbReq,
    input  wbRsp_t             wbRsp,
    input  logic               take,
    output instWord_u          instWord,
    output logic [`ADDR_W-1:0] instAddr,
    output logic               bufValid
);

    logic [`ADDR_W-1:0] pc;
    logic               busy;     // A read is outstanding on the bus
    logic               ackSeen;
    logic               bufFree;

    assign ackSeen = busy && wbRsp.ack;
    assign bufFree = !bufValid || take;  // Empty now or emptied on this edge

    // Classic read cycle, address held by the PC until ack
    assign wbReq = '{cyc: busy, stb: busy, we: 1'b0, adr: pc};

    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc       <= `RESET_PC;
            busy     <= 1'b0;
            bufValid <= 1'b0;
        end else begin
            if (ackSeen) begin
                pc   <= pc + `INST_STEP;
                busy <= 1'b0;  // Cycle ends, no back-to-back strobe
            end else if (!busy && bufFree) begin
                busy <= 1'b1;
            end

            if (ackSeen) begin
                bufValid <= 1'b1;
            end else if (take) begin
                bufValid <= 1'b0;
            end
        end
    end

    // Buffer payload, loaded only when a word arrives
    always_ff @(posedge clk) begin
        if (ackSeen) begin
            instWord <= wbRsp.dat;
            instAddr <= pc;
        end
    end

endmodule

//--- rv32Decoder.sv
`timescale 1ns/1ps
`include "frontEndParams.svh"

module rv32Decoder import frontEndPkg::*; (
    input  logic               clk,
    input  logic               rstN,
    input  instWord_u          instWord,
    input  logic [`ADDR_W-1:0] instAddr,
    input  logic               bufValid,
    input  logic               stall,
    output logic               take,
    output decodedInst_t       decOut,
    output logic               decValid
);

    localparam logic [6:0] Funct7Base = 7'b0000000;
    localparam logic [6:0] Funct7Alt  = 7'b0100000;  // SUB and SRA/SRAI

    logic [6:0]       opcode;
    logic [2:0]       funct3;
    logic [6:0]       funct7;
    logic [`XLEN-1:0] immI;
    logic [`XLEN-1:0] immS;
    logic [`XLEN-1:0] immB;
    logic [`XLEN-1:0] immU;
    logic [`XLEN-1:0] immJ;
    logic [`XLEN-1:0] nextImm;
    opCode_e          nextOp;
    opClass_e         nextClass;
    decodedInst_t     nextRec;
    logic             canLoad;

    assign opcode = instWord.rType.opcode;
    assign funct3 = instWord.iType.funct3;
    assign funct7 = instWord.rType.funct7;

    assign immI = {{20{instWord.iType.imm[11]}}, instWord.iType.imm};
    assign immS = {{20{instWord.sType.immHi[6]}}, instWord.sType.immHi, instWord.sType.immLo};
    assign immB = {{19{instWord.bType.immSign}}, instWord.bType.immSign, instWord.bType.imm11,
                   instWord.bType.immHi, instWord.bType.immLo, 1'b0};
    assign immU = {instWord.uType.imm, 12'b0};
    assign immJ = {{11{instWord.jType.immSign}}, instWord.jType.immSign, instWord.jType.immHi,
                   instWord.jType.imm11, instWord.jType.immLo, 1'b0};

    always_comb begin
        nextOp  = ILLEGAL;
        nextImm = '0;  // R-type and unknown opcodes carry no immediate
        case (opcode)
            ClassLui: begin
                nextOp  = LUI;
                nextImm = immU;
            end
            ClassAuipc: begin
                nextOp  = AUIPC;
                nextImm = immU;
            end
            ClassJal: begin
                nextOp  = JAL;
                nextImm = immJ;
            end
            ClassJalr: begin
                nextImm = immI;
                if (funct3 == 3'b000) begin
                    nextOp = JALR;
                end
            end
            ClassBranch: begin
                nextImm = immB;
                case (funct3)
                    3'b000: nextOp = BEQ;
                    3'b001: nextOp = BNE;
                    3'b100: nextOp = BLT;
                    3'b101: nextOp = BGE;
                    3'b110: nextOp = BLTU;
                    3'b111: nextOp = BGEU;
                    default: ;
                endcase
            end
            ClassLoad: begin
                nextImm = immI;
                case (funct3)
                    3'b000: nextOp = LB;
                    3'b001: nextOp = LH;
                    3'b010: nextOp = LW;
                    3'b100: nextOp = LBU;
                    3'b101: nextOp = LHU;
                    default: ;
                endcase
            end
            ClassStore: begin
                nextImm = immS;
                case (funct3)
                    3'b000: nextOp = SB;
                    3'b001: nextOp = SH;
                    3'b010: nextOp = SW;
                    default: ;
                endcase
            end
            ClassOpImm: begin
                nextImm = immI;
                case (funct3)
                    3'b000: nextOp = ADDI;
                    3'b010: nextOp = SLTI;
                    3'b011: nextOp = SLTIU;
                    3'b100: nextOp = XORI;
                    3'b110: nextOp = ORI;
                    3'b111: nextOp = ANDI;
                    3'b001: begin
                        if (funct7 == Funct7Base) begin
                            nextOp = SLLI;
                        end
                    end
                    3'b101: begin
                        if (funct7 == Funct7Base) begin
                            nextOp = SRLI;
                        end else if (funct7 == Funct7Alt) begin
                            nextOp = SRAI;
                        end
                    end
                    default: ;
                endcase
            end
            ClassOp: begin
                if (funct7 == Funct7Base) begin
                    case (funct3)
                        3'b000: nextOp = ADD;
                        3'b001: nextOp = SLL;
                        3'b010: nextOp = SLT;
                        3'b011: nextOp = SLTU;
                        3'b100: nextOp = XOR;
                        3'b101: nextOp = SRL;
                        3'b110: nextOp = OR;
                        3'b111: nextOp = AND;
                        default: ;
                    endcase
                end else if (funct7 == Funct7Alt) begin
                    case (funct3)
                        3'b000: nextOp = SUB;
                        3'b101: nextOp = SRA;
                        default: ;
                    endcase
                end
            end
            default: ;
        endcase
    end

    // The class is the opcode field itself unless decode failed
    assign nextClass = (nextOp == ILLEGAL) ? ClassNop : opClass_e'(opcode);

    assign nextRec = '{
        rs1Name:  instWord.rType.rs1,
        rs2Name:  instWord.rType.rs2,
        rdName:   instWord.rType.rd,
        opCode:   nextOp,
        opClass:  nextClass,
        instAddr: instAddr,
        imm:      nextImm
    };

    assign canLoad = !decValid || !stall;  // A stalled valid record must hold
    assign take    = bufValid && canLoad;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            decValid       <= 1'b0;
            decOut.opCode  <= NOP;
            decOut.opClass <= ClassNop;
        end else begin
            if (canLoad) begin
                decValid <= bufValid;
            end
            if (take) begin
                decOut <= nextRec;
            end
        end
    end

endmodule

//--- decodeFrontEnd.sv
`timescale 1ns/1ps
`include "frontEndParams.svh"

module decodeFrontEnd import frontEndPkg::*; (
    input  logic         clk,
    input  logic         rstN,
    output wbReq_t       wbReq,
    input  wbRsp_t       wbRsp,
    input  logic         stall,
    output decodedInst_t decOut,
    output logic         decValid
);

    instWord_u          instWord;
    logic [`ADDR_W-1:0] instAddr;
    logic               bufValid;
    logic               take;

    instFetch fetch (
        .clk      (clk),
        .rstN     (rstN),
        .wbReq    (wbReq),
        .wbRsp    (wbRsp),
        .take     (take),
        .instWord (instWord),
        .instAddr (instAddr),
        .bufValid (bufValid)
    );

    rv32Decoder decoder (
        .clk      (clk),
        .rstN     (rstN),
        .instWord (instWord),
        .instAddr (instAddr),
        .bufValid (bufValid),
        .stall    (stall),
        .take     (take),
        .decOut   (decOut),
        .decValid (decValid)
    );

endmodule

//--- tbInstMem.sv
`timescale 1ns/1ps
`include "frontEndParams.svh"

module tbInstMem import frontEndPkg::*; (
    input  logic   clk,
    input  logic   rstN,
    input  wbReq_t wbReq,
    output wbRsp_t wbRsp
);

    localparam int Depth = 64;

    logic [`XLEN-1:0] mem [Depth];  // Program image, written by the testbench before reset ends
    logic             pending;
    logic [1:0]       waitLeft;
    logic [`XLEN-1:0] readData;

    // Addresses past the image read as zero
    assign readData = (wbReq.adr < `ADDR_W'(Depth * 4)) ? mem[wbReq.adr[7:2]] : '0;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            wbRsp.ack <= 1'b0;
            wbRsp.dat <= '0;
            pending   <= 1'b0;
            waitLeft  <= '0;
        end else if (wbRsp.ack) begin
            wbRsp.ack <= 1'b0;  // Master ends the cycle on this edge
        end else if (wbReq.cyc && wbReq.stb) begin
            if (!pending) begin
                pending  <= 1'b1;
                waitLeft <= 2'($urandom_range(3, 0));  // Extra wait states for this read
            end else if (waitLeft == 2'd0) begin
                pending   <= 1'b0;
                wbRsp.ack <= 1'b1;
                wbRsp.dat <= readData;
            end else begin
                waitLeft <= waitLeft - 2'd1;
            end
        end
    end

endmodule

//--- tb_decodeFrontEnd.sv
`timescale 1ns/1ps
`include "frontEndParams.svh"

module tb_decodeFrontEnd import frontEndPkg::*; ();

    localparam int NumRecords    = 64;
    localparam int ImageWords    = 64;
    localparam int TimeoutCycles = NumRecords * 12 + 50;
    localparam int NumTests      = 6;
    localparam int TReset        = 0;
    localparam int TBus          = 1;
    localparam int TOrder        = 2;
    localparam int TDecode       = 3;
    localparam int THold         = 4;
    localparam int TIllegal      = 5;

    logic         clk;
    logic         rstN;
    logic         stall;
    wbReq_t       wbReq;
    wbRsp_t       wbRsp;
    decodedInst_t decOut;
    logic         decValid;

    logic [`XLEN-1:0]   image [ImageWords];
    int                 illegalFirst;
    int                 illegalLast;
    string              testName [NumTests] = '{"reset", "wishbone", "address order", "decode",
                                                "stall hold", "illegal"};
    int                 errs [NumTests] = '{default: 0};
    int                 checks [NumTests] = '{default: 0};
    int                 passCount = 0;
    int                 failCount = 0;
    int                 recordCount = 0;
    int                 cycleCount = 0;
    logic               rstPrev = 1'b0;
    bit                 resetDone = 1'b0;
    bit                 reqOpen = 1'b0;
    logic [`ADDR_W-1:0] reqAdr;
    bit                 holdPending = 1'b0;
    decodedInst_t       heldRec;
    logic [`ADDR_W-1:0] expAddr = `RESET_PC;

    decodeFrontEnd DUT (
        .clk      (clk),
        .rstN     (rstN),
        .wbReq    (wbReq),
        .wbRsp    (wbRsp),
        .stall    (stall),
        .decOut   (decOut),
        .decValid (decValid)
    );

    tbInstMem instMem (
        .clk   (clk),
        .rstN  (rstN),
        .wbReq (wbReq),
        .wbRsp (wbRsp)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Reference RV32I decode, written from the ISA encoding tables
    function automatic decodedInst_t refDecode(input logic [31:0] w, input logic [31:0] a);
        opCode_e      branchOps [8] = '{BEQ, BNE, ILLEGAL, ILLEGAL, BLT, BGE, BLTU, BGEU};
        opCode_e      loadOps [8] = '{LB, LH, LW, ILLEGAL, LBU, LHU, ILLEGAL, ILLEGAL};
        opCode_e      storeOps [8] = '{SB, SH, SW, ILLEGAL, ILLEGAL, ILLEGAL, ILLEGAL, ILLEGAL};
        opCode_e      immOps [8] = '{ADDI, SLLI, SLTI, SLTIU, XORI, SRLI, ORI, ANDI};
        opCode_e      regOps [8] = '{ADD, SLL, SLT, SLTU, XOR, SRL, OR, AND};
        opCode_e      altOps [8] = '{SUB, ILLEGAL, ILLEGAL, ILLEGAL, ILLEGAL, SRA, ILLEGAL, ILLEGAL};
        decodedInst_t r;
        logic [2:0]   f3;
        logic [6:0]   f7;
        f3 = w[14:12];
        f7 = w[31:25];
        r = '0;
        r.rs1Name = w[19:15];
        r.rs2Name = w[24:20];
        r.rdName = w[11:7];
        r.instAddr = a;
        case (w[6:0])
            7'h37: r.opCode = LUI;
            7'h17: r.opCode = AUIPC;
            7'h6f: r.opCode = JAL;
            7'h67: r.opCode = (f3 == 3'd0) ? JALR : ILLEGAL;
            7'h63: r.opCode = branchOps[f3];
            7'h03: r.opCode = loadOps[f3];
            7'h23: r.opCode = storeOps[f3];
            7'h13: begin
                r.opCode = immOps[f3];
                if (f3 == 3'd5 && f7 == 7'h20) begin
                    r.opCode = SRAI;
                end else if ((f3 == 3'd1 || f3 == 3'd5) && f7 != 7'h00) begin
                    r.opCode = ILLEGAL;  // Shift amount field is only five bits
                end
            end
            7'h33: r.opCode = (f7 == 7'h00) ? regOps[f3] : (f7 == 7'h20) ? altOps[f3] : ILLEGAL;
            default: r.opCode = ILLEGAL;
        endcase
        case (w[6:0])
            7'h37, 7'h17: r.imm = {w[31:12], 12'b0};
            7'h6f: r.imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            7'h67, 7'h03, 7'h13: r.imm = {{20{w[31]}}, w[31:20]};
            7'h23: r.imm = {{20{w[31]}}, w[31:25], w[11:7]};
            7'h63: r.imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            default: r.imm = '0;
        endcase
        r.opClass = (r.opCode == ILLEGAL) ? ClassNop : opClass_e'(w[6:0]);
        return r;
    endfunction

    task automatic buildImage();
        logic [6:0]   classes [9] = '{7'h37, 7'h17, 7'h6f, 7'h67, 7'h63, 7'h03, 7'h23, 7'h13,
                                      7'h33};
        logic [16:0]  badForms [13] = '{  // Opcode, funct3, funct7
            {7'h13, 3'd1, 7'h20}, {7'h13, 3'd5, 7'h01}, {7'h33, 3'd0, 7'h01},
            {7'h33, 3'd5, 7'h40}, {7'h33, 3'd1, 7'h20}, {7'h67, 3'd2, 7'h00},
            {7'h63, 3'd3, 7'h00}, {7'h03, 3'd7, 7'h00}, {7'h23, 3'd5, 7'h00},
            {7'h0f, 3'd0, 7'h00}, {7'h73, 3'd0, 7'h00}, {7'h7f, 3'd2, 7'h11},
            {7'h2b, 3'd1, 7'h05}};
        bit           seenOp [64] = '{default: 1'b0};
        decodedInst_t r;
        logic [31:0]  w;
        int           n;
        n = 0;
        foreach (classes[c]) begin
            for (int f3 = 0; f3 < 8; f3++) begin
                for (int alt = 0; alt < 3; alt++) begin
                    w = $urandom;
                    w[6:0] = classes[c];
                    w[14:12] = 3'(f3);
                    if (alt == 1)
                        w[31:25] = 7'h00;
                    else if (alt == 2)
                        w[31:25] = 7'h20;
                    r = refDecode(w, '0);
                    if (r.opCode != ILLEGAL && !seenOp[int'(r.opCode)]) begin
                        seenOp[int'(r.opCode)] = 1'b1;  // Keep one word per legal form
                        image[n] = w;
                        n++;
                    end
                end
            end
        end
        illegalFirst = n;
        foreach (badForms[b]) begin
            w = $urandom;
            w[6:0] = badForms[b][16:10];
            w[14:12] = badForms[b][9:7];
            w[31:25] = badForms[b][6:0];
            image[n] = w;
            n++;
        end
        illegalLast = n - 1;
        while (n < ImageWords) begin
            image[n] = $urandom;
            n++;
        end
        foreach (image[i])
            instMem.mem[i] = image[i];
    endtask

    task automatic expectEqual(input int t, input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        checks[t]++;
        assert (got === exp) else begin
            $display("FAIL %s expected %h got %h", name, exp, got);
            errs[t]++;
        end
    endtask

    task automatic reportTest(input int t);
        if (checks[t] == 0) begin
            $display("Test %s: no check was ever reached", testName[t]);
            failCount++;
        end else if (errs[t] != 0) begin
            $display("Test %s: %0d of %0d checks wrong", testName[t], errs[t], checks[t]);
            failCount++;
        end else begin
            $display("Test %s: all %0d checks passed", testName[t], checks[t]);
            passCount++;
        end
    endtask

    always @(posedge clk) begin
        decodedInst_t expRec;
        int           idx;
        cycleCount++;
        if (cycleCount > 1 && (!rstN || !rstPrev)) begin
            expectEqual(TReset, "wbReq.cyc", 128'(wbReq.cyc), 128'(0));
            expectEqual(TReset, "wbReq.stb", 128'(wbReq.stb), 128'(0));
            expectEqual(TReset, "decValid", 128'(decValid), 128'(0));
        end else if (rstN && !resetDone) begin
            resetDone = 1'b1;
            reportTest(TReset);
        end
        if (rstN) begin
            if (wbReq.stb)
                expectEqual(TBus, "wbReq.cyc", 128'(wbReq.cyc), 128'(1));
            if (wbReq.cyc) begin
                expectEqual(TBus, "wbReq.we", 128'(wbReq.we), 128'(0));
                if (reqOpen)
                    expectEqual(TBus, "wbReq.adr", 128'(wbReq.adr), 128'(reqAdr));
                reqOpen = !wbRsp.ack;  // Request closes on the ack edge
                reqAdr = wbReq.adr;
            end
        end
        if (rstN && recordCount < NumRecords) begin
            if (holdPending) begin
                expectEqual(THold, "decValid", 128'(decValid), 128'(1));
                expectEqual(THold, "decOut", 128'(decOut), 128'(heldRec));
            end
            holdPending = decValid && stall;
            heldRec = decOut;
            if (decValid && !stall) begin  // Dispatcher accepts the record on this edge
                idx = int'(expAddr >> 2);
                expRec = refDecode(image[idx], expAddr);
                expectEqual(TOrder, "decOut.instAddr", 128'(decOut.instAddr), 128'(expAddr));
                expectEqual(TDecode, "decOut", 128'(decOut), 128'(expRec));
                if (idx >= illegalFirst && idx <= illegalLast) begin
                    expectEqual(TIllegal, "decOut.opCode", 128'(decOut.opCode), 128'(ILLEGAL));
                    expectEqual(TIllegal, "decOut.opClass", 128'(decOut.opClass),
                                128'(ClassNop));
                end
                expAddr = expAddr + `INST_STEP;
                recordCount++;
            end
        end
        rstPrev = rstN;
    end

    initial begin
        void'($urandom(50));
        rstN = 1'b0;
        stall = 1'b0;
        buildImage();
        repeat (10) @(posedge clk);
        rstN <= 1'b1;
        do begin
            @(posedge clk);
            stall <= ($urandom_range(9, 0) < 3);  // Dispatcher busy about 30% of cycles
            @(negedge clk);
        end while (recordCount < NumRecords && cycleCount < TimeoutCycles);
        if (recordCount < NumRecords) begin
            $display("Timeout after %0d cycles with only %0d of %0d records decoded",
                     cycleCount, recordCount, NumRecords);
            failCount++;
        end
        for (int t = TBus; t < NumTests; t++)
            reportTest(t);
        $display("Summary: %0d tests passed, %0d failed, %0d records checked",
                 passCount, failCount, recordCount);
        if (failCount == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

//--- decodeFrontEnd.f
+incdir+.
frontEndPkg.sv
instFetch.sv
rv32Decoder.sv
decodeFrontEnd.sv
tbInstMem.sv
tb_decodeFrontEnd.sv

//--- Makefile
SIM      := verilator
TOP      := tb_decodeFrontEnd
FILELIST := decodeFrontEnd.f
FLAGS    := --binary --timing --assert -j 0 --top-module $(TOP)
BUILDDIR := obj_dir
BIN      := $(BUILDDIR)/V$(TOP)
LOG      := sim.log
SOURCES  := $(shell grep -v '^+' $(FILELIST)) $(wildcard *.svh)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) -f $(FILELIST) -Mdir $(BUILDDIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -qx "Simulation completed successfully" $(LOG)

clean:
	rm -rf $(BUILDDIR) $(LOG)
